/* Makefile */
# Verilator flow for the axi read demux

TB := tb_axi_read_demux

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module $(TB) -o $(TB)
	./obj_dir/$(TB)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f project.f \
		--top-module axi_read_demux

clean:
	rm -rf obj_dir

/* project.f */
source/demux_cfg_pkg.sv
source/axi_read_pkg.sv
source/id_flight_table.sv
source/ar_route_ctrl.sv
source/r_burst_arbiter.sv
source/axi_read_demux.sv
sim/tb_axi_read_demux.sv

/* sim/tb_axi_read_demux.sv */
// ----------------------------------------
// axi read demux testbench
// random upstream master, three modeled slaves
// and a scoreboard for routing and ordering
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_axi_read_demux;

  import demux_cfg_pkg::*;
  import axi_read_pkg::*;

  localparam int unsigned num_reads     = 300;
  localparam int unsigned ar_timeout    = 20000;
  localparam int unsigned drain_timeout = 4000;

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------
  logic                            clk_i          = 1'b0;
  logic                            rst_ni         = 1'b0;
  ar_route_t                       slv_ar_i       = '0;
  logic                            slv_ar_valid_i = 1'b0;
  logic                            slv_ar_ready_o;
  r_chan_t                         slv_r_o;
  logic                            slv_r_valid_o;
  logic                            slv_r_ready_i  = 1'b0;
  ar_chan_t                        mst_ar_o;
  port_vec_t                       mst_ar_valid_o;
  port_vec_t                       mst_ar_ready_i = '0;
  r_chan_t [num_mst_ports-1:0]     mst_r_i        = '0;
  port_vec_t                       mst_r_valid_i  = '0;
  port_vec_t                       mst_r_ready_o;

  // ----------------------------------------
  // model state
  // ----------------------------------------
  integer      seed = 32'ha0cd;
  logic [31:0] rnd;
  ar_route_t   next_ar;
  r_chan_t     next_r;
  ar_chan_t    front;
  int unsigned generated = 0;
  int unsigned accepted  = 0;
  int unsigned completed = 0;
  int unsigned wait_cycles;
  // pending reads in acceptance order
  ar_chan_t    pend_q [$];
  // ARs each slave took and still has to answer
  ar_chan_t    slave_q [num_mst_ports][$];
  logic [7:0]  slave_beat [num_mst_ports] = '{default: '0};
  port_sel_t   ps;
  logic        r_busy;
  // burst currently returning upstream
  logic        in_burst  = 1'b0;
  ar_chan_t    cur_ar    = '0;
  logic [7:0]  up_beat   = '0;
  logic        r_stalled = 1'b0;
  r_chan_t     held_beat = '0;
  int          idx;
  // outstanding reads per low-id slot and the port they went to
  int unsigned slot_cnt [2**look_bits] = '{default: 0};
  port_sel_t   slot_port [2**look_bits];
  look_id_t    slot;
  logic        ar_hs;
  // expected AR routing state
  logic        ar_locked = 1'b0;
  logic        any_full;
  logic        ar_admit;
  logic        ar_shown;
  port_vec_t   exp_vec;

  axi_read_demux UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_i        (mst_r_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_o  (mst_r_ready_o)
  );

  always #20 clk_i = ~clk_i;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // oldest pending read with this full id
  function automatic int oldest_read(input logic [id_width-1:0] id);
    int found;
    found = -1;
    for (int i = pend_q.size() - 1; i >= 0; i--) begin
      if (pend_q[i].id == id) begin
        found = i;
      end
    end
    return found;
  endfunction

  // ----------------------------------------
  // per cycle check and drive
  // ----------------------------------------
  // outputs are sampled at the edge before the DUT flops update
  always @(posedge clk_i) begin
    if (rst_ni) begin
      // admission needs no slot at max_trans and a free slot or one bound to the same port
      // an AR shown to a port stays there until taken
      slot     = slv_ar_i.ar.id[look_bits-1:0];
      any_full = 1'b0;
      for (int s = 0; s < 2**look_bits; s++) begin
        if (slot_cnt[s] >= max_trans) begin
          any_full = 1'b1;
        end
      end
      ar_admit = slv_ar_valid_i && !any_full &&
                 ((slot_cnt[slot] == 0) || (slot_port[slot] == slv_ar_i.sel));
      ar_shown = ar_locked || ar_admit;
      exp_vec  = ar_shown ? (port_vec_t'(1) << slv_ar_i.sel) : '0;
      check_value("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'(exp_vec));
      check_value("slv_ar_ready_o", 64'(slv_ar_ready_o),
                  64'(ar_shown && mst_ar_ready_i[slv_ar_i.sel]));
      if (ar_shown) begin
        check_value("mst_ar_o", 64'(mst_ar_o), 64'(slv_ar_i.ar));
      end
      ar_hs     = slv_ar_valid_i && slv_ar_ready_o;
      ar_locked = ar_shown && !mst_ar_ready_i[slv_ar_i.sel];
      if (ar_hs) begin
        slot_cnt[slot]  = slot_cnt[slot] + 1;
        slot_port[slot] = slv_ar_i.sel;
        pend_q.push_back(slv_ar_i.ar);
        accepted++;
      end

      // upstream R beat holds while stalled
      if (r_stalled) begin
        check_value("slv_r_valid_o", 64'(slv_r_valid_o), 64'(1));
        check_value("slv_r_o", 64'(slv_r_o), 64'(held_beat));
      end
      if (!slv_r_ready_i) begin
        check_value("mst_r_ready_o", 64'(mst_r_ready_o), 64'(0));
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        if (!in_burst) begin
          idx = oldest_read(slv_r_o.id);
          if (idx < 0) begin
            fail_run("an R beat came back for an id with no outstanding read");
          end else begin
            cur_ar = pend_q[idx];
            pend_q.delete(idx);
          end
          in_burst = 1'b1;
          up_beat  = '0;
        end
        // one id all through a burst so bursts cannot interleave
        check_value("slv_r_o.id", 64'(slv_r_o.id), 64'(cur_ar.id));
        check_value("slv_r_o.data", 64'(slv_r_o.data), 64'(cur_ar.addr + 32'(up_beat)));
        check_value("slv_r_o.last", 64'(slv_r_o.last), 64'(up_beat == cur_ar.len));
        if (slv_r_o.last) begin
          in_burst       = 1'b0;
          slot           = slv_r_o.id[look_bits-1:0];
          slot_cnt[slot] = slot_cnt[slot] - 1;
          completed++;
        end else begin
          up_beat = up_beat + 8'd1;
        end
      end
      r_stalled = slv_r_valid_o && !slv_r_ready_i;
      held_beat = slv_r_o;

      // modeled slaves answer in order with gaps
      for (int p = 0; p < num_mst_ports; p++) begin
        ps     = port_sel_t'(p);
        r_busy = mst_r_valid_i[ps];
        if (mst_r_valid_i[ps] && mst_r_ready_o[ps]) begin
          r_busy = 1'b0;
          if (mst_r_i[ps].last) begin
            slave_q[ps].delete(0);
            slave_beat[ps] = '0;
          end else begin
            slave_beat[ps] = slave_beat[ps] + 8'd1;
          end
        end
        if (mst_ar_valid_o[ps] && mst_ar_ready_i[ps]) begin
          slave_q[ps].push_back(mst_ar_o);
        end
        rnd = $random(seed);
        mst_ar_ready_i[ps] <= rnd[0];
        if (!r_busy) begin
          if ((slave_q[ps].size() != 0) && (rnd[2:1] != 2'b00)) begin
            front       = slave_q[ps][0];
            next_r.id   = front.id;
            next_r.data = front.addr + 32'(slave_beat[ps]);
            next_r.last = (slave_beat[ps] == front.len);
            mst_r_i[ps]       <= next_r;
            mst_r_valid_i[ps] <= 1'b1;
          end else begin
            mst_r_valid_i[ps] <= 1'b0;
          end
        end
      end

      // upstream master holds its request until accepted
      if (!slv_ar_valid_i || ar_hs) begin
        rnd = $random(seed);
        if ((generated < num_reads) && rnd[0]) begin
          next_ar.ar.id   = rnd[4:1];
          next_ar.ar.len  = {6'b0, rnd[6:5]};
          next_ar.sel     = port_sel_t'(rnd[31:8] % 24'd3);
          next_ar.ar.addr = $random(seed);
          slv_ar_i       <= next_ar;
          slv_ar_valid_i <= 1'b1;
          generated++;
        end else begin
          slv_ar_valid_i <= 1'b0;
        end
      end
      rnd = $random(seed);
      slv_r_ready_i <= rnd[0] | rnd[1];
    end
  end

  // ----------------------------------------
  // run control
  // ----------------------------------------
  initial begin
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // all requests accepted upstream
    wait_cycles = 0;
    while (accepted < num_reads) begin
      @(posedge clk_i);
      wait_cycles++;
      if (wait_cycles > ar_timeout) begin
        fail_run("timeout while the upstream AR requests were still being accepted");
      end
    end

    // every burst returned
    wait_cycles = 0;
    while (completed < accepted) begin
      @(posedge clk_i);
      wait_cycles++;
      if (wait_cycles > drain_timeout) begin
        fail_run("timeout while waiting for the outstanding bursts to complete");
      end
    end

    if (pend_q.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      fail_run("some reads were left without a response");
    end
  end

endmodule

`default_nettype wire

/* source/ar_route_ctrl.sv */
// ----------------------------------------
// AR route control
// admits upstream AR requests against the
// flight table and fans them out to one port
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ar_route_ctrl (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // upstream AR
  input  wire axi_read_pkg::ar_route_t  slv_ar_i,
  input  wire logic                     slv_ar_valid_i,
  output logic                          slv_ar_ready_o,
  // downstream AR, payload shared by all ports
  output axi_read_pkg::ar_chan_t        mst_ar_o,
  output demux_cfg_pkg::port_vec_t      mst_ar_valid_o,
  input  wire demux_cfg_pkg::port_vec_t mst_ar_ready_i,
  // flight table answers
  input  wire demux_cfg_pkg::port_sel_t lookup_sel_i,
  input  wire logic                     lookup_busy_i,
  input  wire logic                     table_full_i,
  // flight table push
  output logic                          push_o,
  output demux_cfg_pkg::look_id_t       push_id_o,
  output demux_cfg_pkg::port_sel_t      push_sel_o
);

  import demux_cfg_pkg::*;

  // request may go out this cycle
  logic admit;
  // valid towards the selected port and its ready
  logic ar_valid;
  logic ar_ready;
  // keeps the valid up once it was shown to a port
  logic lock_q;

  // ----------------------------------------
  // admission
  // ----------------------------------------
  // slot must be free or already heading to the same port,
  // otherwise responses could return out of order
  assign admit = slv_ar_valid_i && !table_full_i &&
                 (!lookup_busy_i || (slv_ar_i.sel == lookup_sel_i));

  // locked valid wins even if admission drops meanwhile
  assign ar_valid = lock_q || admit;

  // ----------------------------------------
  // fan-out
  // ----------------------------------------
  assign mst_ar_o = slv_ar_i.ar;

  always_comb begin
    mst_ar_valid_o = '0;
    ar_ready       = 1'b0;
    for (int unsigned i = 0; i < num_mst_ports; i++) begin
      if (ar_valid && (slv_ar_i.sel == port_sel_t'(i))) begin
        mst_ar_valid_o[i] = 1'b1;
        ar_ready          = mst_ar_ready_i[i];
      end
    end
  end

  // ready goes straight back upstream
  assign slv_ar_ready_o = ar_valid && ar_ready;

  // ----------------------------------------
  // flight table push
  // ----------------------------------------
  assign push_o     = ar_valid && ar_ready;
  assign push_id_o  = slv_ar_i.ar.id[look_bits-1:0];
  assign push_sel_o = slv_ar_i.sel;

  // ----------------------------------------
  // valid lock
  // ----------------------------------------
  // set while the port stalls, dropped on the transfer
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= ar_valid && !ar_ready;
    end
  end

  // downstream valid must not fall or move before ready
  ar_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ar_valid && !ar_ready) |=> (mst_ar_valid_o == $past(mst_ar_valid_o)))
    else $error("AR valid dropped under stall");

  // payload must hold while the port stalls
  ar_payload_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ar_valid && !ar_ready) |=> $stable(mst_ar_o))
    else $error("AR payload changed under stall");

endmodule

`default_nettype wire

/* source/axi_read_demux.sv */
// ----------------------------------------
// axi read demux
// routes upstream AR to one of three ports
// and merges their R bursts back upstream
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module axi_read_demux (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // upstream port
  input  wire axi_read_pkg::ar_route_t  slv_ar_i,
  input  wire logic                     slv_ar_valid_i,
  output logic                          slv_ar_ready_o,
  output axi_read_pkg::r_chan_t         slv_r_o,
  output logic                          slv_r_valid_o,
  input  wire logic                     slv_r_ready_i,
  // downstream ports
  output axi_read_pkg::ar_chan_t        mst_ar_o,
  output demux_cfg_pkg::port_vec_t      mst_ar_valid_o,
  input  wire demux_cfg_pkg::port_vec_t mst_ar_ready_i,
  input  wire axi_read_pkg::r_chan_t [demux_cfg_pkg::num_mst_ports-1:0] mst_r_i,
  input  wire demux_cfg_pkg::port_vec_t mst_r_valid_i,
  output demux_cfg_pkg::port_vec_t      mst_r_ready_o
);

  import demux_cfg_pkg::*;

  // ----------------------------------------
  // internal wires
  // ----------------------------------------
  port_sel_t lookup_sel;
  logic      lookup_busy;
  logic      table_full;
  logic      push;
  look_id_t  push_id;
  port_sel_t push_sel;
  logic      pop;
  look_id_t  pop_id;

  // AR admission and fan-out
  ar_route_ctrl i_ar_route_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .lookup_sel_i   (lookup_sel),
    .lookup_busy_i  (lookup_busy),
    .table_full_i   (table_full),
    .push_o         (push),
    .push_id_o      (push_id),
    .push_sel_o     (push_sel)
  );

  // push slot is always the slot of the waiting request,
  // so it also drives the lookup
  id_flight_table i_id_flight_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_id_i   (push_id),
    .lookup_sel_o  (lookup_sel),
    .lookup_busy_o (lookup_busy),
    .full_o        (table_full),
    .push_i        (push),
    .push_id_i     (push_id),
    .push_sel_i    (push_sel),
    .pop_i         (pop),
    .pop_id_i      (pop_id)
  );

  // R merge, pops the table on each last beat
  r_burst_arbiter i_r_burst_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mst_r_i       (mst_r_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_o       (slv_r_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .pop_o         (pop),
    .pop_id_o      (pop_id)
  );

endmodule

`default_nettype wire

/* source/axi_read_pkg.sv */
// ----------------------------------------
// axi read channels
// AR and R payloads plus the AR request
// bundled with its routing choice
// ----------------------------------------

package axi_read_pkg;

  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned len_width  = 8;

  // ----------------------------------------
  // address read
  // ----------------------------------------
  // burst carries len+1 beats
  typedef struct packed {
    logic [demux_cfg_pkg::id_width-1:0] id;
    logic [addr_width-1:0]              addr;
    logic [len_width-1:0]               len;
  } ar_chan_t;

  // ----------------------------------------
  // read data
  // ----------------------------------------
  typedef struct packed {
    logic [demux_cfg_pkg::id_width-1:0] id;
    logic [data_width-1:0]              data;
    logic                               last;
  } r_chan_t;

  // ----------------------------------------
  // routed request
  // ----------------------------------------
  // sel picks the downstream port, must stay below num_mst_ports
  typedef struct packed {
    ar_chan_t                 ar;
    demux_cfg_pkg::port_sel_t sel;
  } ar_route_t;

endpackage

/* source/demux_cfg_pkg.sv */
// ----------------------------------------
// demux configuration
// sizing constants, port select and in-flight
// counter types of the read demux
// ----------------------------------------

package demux_cfg_pkg;

  // downstream ports and their select
  localparam int unsigned num_mst_ports = 3;
  localparam int unsigned sel_width     = 2;
  typedef logic [sel_width-1:0] port_sel_t;

  // full axi id and the low bits tracked per slot
  localparam int unsigned id_width  = 4;
  localparam int unsigned look_bits = 2;
  typedef logic [look_bits-1:0] look_id_t;

  // reads in flight per slot, slot is full at max_trans
  localparam int unsigned max_trans = 3;
  localparam int unsigned cnt_width = 2;
  typedef logic [cnt_width-1:0] flight_cnt_t;

  // one bit per downstream port
  typedef logic [num_mst_ports-1:0] port_vec_t;

endpackage

/* source/id_flight_table.sv */
// ----------------------------------------
// id flight table
// per low-id slot in-flight counters and the
// downstream port each slot was last sent to
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module id_flight_table (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // lookup for the request waiting upstream
  input  wire demux_cfg_pkg::look_id_t  lookup_id_i,
  output demux_cfg_pkg::port_sel_t      lookup_sel_o,
  output logic                          lookup_busy_o,
  output logic                          full_o,
  // push on AR transfer
  input  wire logic                     push_i,
  input  wire demux_cfg_pkg::look_id_t  push_id_i,
  input  wire demux_cfg_pkg::port_sel_t push_sel_i,
  // pop on last R beat upstream
  input  wire logic                     pop_i,
  input  wire demux_cfg_pkg::look_id_t  pop_id_i
);

  import demux_cfg_pkg::*;

  // in-flight count and remembered port per slot
  flight_cnt_t cnt_q [2**look_bits];
  port_sel_t   sel_q [2**look_bits];

  // per slot full flags, or-reduced into full_o
  logic [2**look_bits-1:0] slot_full;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  assign lookup_sel_o  = sel_q[lookup_id_i];
  assign lookup_busy_o = (cnt_q[lookup_id_i] != '0);
  assign full_o        = |slot_full;

  // ----------------------------------------
  // counters
  // ----------------------------------------
  for (genvar i = 0; i < 2**look_bits; i++) begin : gen_slot
    logic push_hit;
    logic pop_hit;

    assign push_hit     = push_i && (push_id_i == look_id_t'(i));
    assign pop_hit      = pop_i && (pop_id_i == look_id_t'(i));
    assign slot_full[i] = (cnt_q[i] == flight_cnt_t'(max_trans));

    // push and pop on the same slot leave the count alone
    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (push_hit && !pop_hit) begin
        // saturate at the top
        if (!slot_full[i]) begin
          cnt_q[i] <= cnt_q[i] + flight_cnt_t'(1);
        end
      end else if (pop_hit && !push_hit) begin
        if (cnt_q[i] != '0) begin
          cnt_q[i] <= cnt_q[i] - flight_cnt_t'(1);
        end
      end
    end

    // port is reloaded on every push
    always_ff @(posedge clk_i) begin
      if (push_hit) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

  // a last beat upstream must match a burst that was sent out
  pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (cnt_q[pop_id_i] != '0))
    else $error("pop on empty slot %0d", pop_id_i);

endmodule

`default_nettype wire

/* source/r_burst_arbiter.sv */
// ----------------------------------------
// R burst arbiter
// round-robin merge of the downstream R
// beats, a burst keeps the grant until last
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module r_burst_arbiter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // downstream R
  input  wire axi_read_pkg::r_chan_t [demux_cfg_pkg::num_mst_ports-1:0] mst_r_i,
  input  wire demux_cfg_pkg::port_vec_t                                 mst_r_valid_i,
  output demux_cfg_pkg::port_vec_t                                      mst_r_ready_o,
  // upstream R
  output axi_read_pkg::r_chan_t       slv_r_o,
  output logic                        slv_r_valid_o,
  input  wire logic                   slv_r_ready_i,
  // flight table pop
  output logic                        pop_o,
  output demux_cfg_pkg::look_id_t     pop_id_o
);

  import demux_cfg_pkg::*;

  // ports allowed to request, all open between bursts
  port_vec_t burst_mask_q;
  port_vec_t req;
  // next port to get priority
  port_sel_t rr_q;
  // grant held while the upstream stalls
  logic      hold_q;
  port_sel_t gnt_q;
  // round-robin pick for this cycle
  logic      pick_found;
  port_sel_t pick_idx;
  port_sel_t sel_idx;
  logic      xfer;

  assign req = mst_r_valid_i & burst_mask_q;

  // ----------------------------------------
  // round-robin pick
  // ----------------------------------------
  // search starts at rr_q and wraps around
  always_comb begin
    int unsigned k;
    pick_found = 1'b0;
    pick_idx   = rr_q;
    for (int unsigned off = 0; off < num_mst_ports; off++) begin
      k = (int'(rr_q) + off) % num_mst_ports;
      if (!pick_found && req[k]) begin
        pick_found = 1'b1;
        pick_idx   = port_sel_t'(k);
      end
    end
  end

  // stalled beat keeps its port
  assign sel_idx = hold_q ? gnt_q : pick_idx;

  // ----------------------------------------
  // merge
  // ----------------------------------------
  assign slv_r_o       = mst_r_i[sel_idx];
  assign slv_r_valid_o = req[sel_idx];
  assign xfer          = slv_r_valid_o && slv_r_ready_i;

  // only the granted port sees ready, and only on a transfer
  always_comb begin
    mst_r_ready_o = '0;
    if (xfer) begin
      mst_r_ready_o[sel_idx] = 1'b1;
    end
  end

  // last beat releases the slot in the flight table
  assign pop_o    = xfer && slv_r_o.last;
  assign pop_id_o = slv_r_o.id[look_bits-1:0];

  // ----------------------------------------
  // grant, burst mask, pointer
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      hold_q       <= 1'b0;
      gnt_q        <= '0;
      burst_mask_q <= '1;
      rr_q         <= '0;
    end else begin
      hold_q <= slv_r_valid_o && !slv_r_ready_i;
      if (slv_r_valid_o) begin
        gnt_q <= sel_idx;
      end
      if (xfer) begin
        if (slv_r_o.last) begin
          // burst done, reopen all ports and move past the winner
          burst_mask_q <= '1;
          rr_q         <= (sel_idx == port_sel_t'(num_mst_ports - 1)) ? '0 :
                          sel_idx + port_sel_t'(1);
        end else begin
          // lock out the other ports mid burst
          burst_mask_q                  <= '0;
          burst_mask_q[sel_idx]         <= 1'b1;
        end
      end
    end
  end

  // upstream beat holds while the master stalls
  r_payload_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_r_valid_o && !slv_r_ready_i) |=> (slv_r_valid_o && $stable(slv_r_o)))
    else $error("R beat changed under stall");

endmodule

`default_nettype wire
